// ==== Makefile ====
# Verilator build and run of the circle display testbench
VERILATOR ?= verilator
TOP       ?= circle_display_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove the build folder and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "All checks passed" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+hw
hw/display_pkg.sv
hw/video_if.sv
hw/raster_timing.sv
hw/circle_test.sv
hw/pixel_shader.sv
hw/circle_display.sv
test/circle_display_assertions.sv
test/circle_display_tb.sv

// ==== hw/circle_display.sv ====
`timescale 1ns/1ps

module circle_display (
    input  logic                clk,
    input  logic                reset,
    output logic                hsync,
    output logic                vsync,
    output display_pkg::pixel_t rgb
);

    // Raster bundle shared by all three stages
    video_if vid0 ();

    // Comparator answer, one pixel behind the raster
    logic in_circle;

    //////////////////////////////
    // Coordinate source
    //////////////////////////////

    raster_timing raster0 (
        .clk   (clk),
        .reset (reset),
        .vid   (vid0.source)
    );

    //////////////////////////////
    // Inside test
    //////////////////////////////

    circle_test circle0 (
        .clk       (clk),
        .reset     (reset),
        .vid       (vid0.compare),
        .in_circle (in_circle)
    );

    //////////////////////////////
    // Colour and sync alignment
    //////////////////////////////

    // Outputs lag the raster by one pixel, 4 clocks
    pixel_shader shader0 (
        .clk       (clk),
        .reset     (reset),
        .vid       (vid0.shade),
        .in_circle (in_circle),
        .hsync     (hsync),
        .vsync     (vsync),
        .rgb       (rgb)
    );

endmodule

// ==== hw/circle_test.sv ====
`timescale 1ns/1ps
`include "display_consts.svh"

module circle_test (
    input  logic     clk,
    input  logic     reset,
    video_if.compare vid,
    output logic     in_circle
);

    import display_pkg::*;

    circle_state_t state;

    // Multiplier operand, x offset first then y offset
    offset_t mul_op;
    // y offset parked while x is squared
    offset_t y_off;
    square_t x_sq;
    square_t y_sq;

    // Shared squarer, one per design
    square_t product;
    assign product = mul_op * mul_op;

    //////////////////////////////
    // Four clocks per pixel
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= INIT;
            in_circle <= 1'b0;
        end else begin
            case (state)
                // Tick cycle, grab centred offsets
                INIT: begin
                    if (vid.pixel_tick) begin
                        mul_op <= offset_t'(vid.x - `CENTER_X);
                        y_off  <= offset_t'(vid.y - `CENTER_Y);
                        state  <= SQUARE_X;
                    end
                end

                // dx squared, then load dy into the multiplier
                SQUARE_X: begin
                    x_sq   <= product;
                    mul_op <= y_off;
                    state  <= SQUARE_Y;
                end

                // dy squared, x_sq carried forward unchanged
                SQUARE_Y: begin
                    y_sq  <= product;
                    state <= ADD_CMP;
                end

                // Strictly inside, boundary pixels count as outside
                ADD_CMP: begin
                    in_circle <= (square_t'(x_sq + y_sq) < `RADIUS_SQ);
                    state     <= INIT;
                end

                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

endmodule

// ==== hw/display_consts.svh ====
`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

//////////////////////////////
// 640x480 horizontal timing
//////////////////////////////

// All counts in pixels
`define H_ACTIVE        640
`define H_SYNC_START    656
`define H_SYNC_END      752
`define H_TOTAL         800

//////////////////////////////
// 640x480 vertical timing
//////////////////////////////

// All counts in lines
`define V_ACTIVE        480
`define V_SYNC_START    490
`define V_SYNC_END      492
`define V_TOTAL         525

// System clocks per pixel
// Must match the number of comparator states
`define CLKS_PER_PIXEL  4

// Circle placed in the middle of the screen, radius 100
`define CENTER_X        320
`define CENTER_Y        240
`define RADIUS_SQ       10000

// Colours in RGB 4:4:4
`define INSIDE_COLOR    12'hF00
`define OUTSIDE_COLOR   12'h00F

`endif

// ==== hw/display_pkg.sv ====
package display_pkg;

    //////////////////////////////
    // Screen and colour vectors
    //////////////////////////////

    // Raster position, covers 0 to 799 horizontally
    typedef logic [9:0] coord_t;

    // Position relative to the circle centre
    // Range is -320 to 479 in x, -240 to 284 in y
    typedef logic signed [9:0] offset_t;

    // Square of an offset, or the sum of two
    // Worst case 479^2 + 284^2 still fits below 2^19
    typedef logic signed [19:0] square_t;

    // Packed colour, red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] pixel_t;

    //////////////////////////////
    // Comparator FSM
    //////////////////////////////

    // One state per system clock of a pixel
    typedef enum logic [1:0] {
        INIT     = 2'b00,
        SQUARE_X = 2'b01,
        SQUARE_Y = 2'b10,
        ADD_CMP  = 2'b11
    } circle_state_t;

endpackage

// ==== hw/pixel_shader.sv ====
`timescale 1ns/1ps
`include "display_consts.svh"

module pixel_shader (
    input  logic                clk,
    input  logic                reset,
    video_if.shade              vid,
    input  logic                in_circle,
    output logic                hsync,
    output logic                vsync,
    output display_pkg::pixel_t rgb
);

    //////////////////////////////
    // One pixel delay line
    //////////////////////////////

    // Timing levels of the pixel now in the comparator
    logic active_d;
    logic hsync_d;
    logic vsync_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
        end else if (vid.pixel_tick) begin
            active_d <= vid.active;
            hsync_d  <= vid.hsync;
            vsync_d  <= vid.vsync;
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    // in_circle at the tick belongs to the previous pixel,
    // same as the *_d levels
    always_ff @(posedge clk) begin
        if (reset) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            rgb   <= '0;
        end else if (vid.pixel_tick) begin
            hsync <= hsync_d;
            vsync <= vsync_d;
            if (!active_d) begin
                // Blanking must be black for the monitor
                rgb <= '0;
            end else if (in_circle) begin
                rgb <= `INSIDE_COLOR;
            end else begin
                rgb <= `OUTSIDE_COLOR;
            end
        end
    end

endmodule

// ==== hw/raster_timing.sv ====
`timescale 1ns/1ps
`include "display_consts.svh"

module raster_timing (
    input  logic     clk,
    input  logic     reset,
    video_if.source  vid
);

    import display_pkg::*;

    //////////////////////////////
    // Pixel strobe
    //////////////////////////////

    // Two bits cover CLKS_PER_PIXEL of 4
    logic [1:0] phase;
    logic       tick;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= 2'd0;
        end else if (phase == 2'(`CLKS_PER_PIXEL - 1)) begin
            phase <= 2'd0;
        end else begin
            phase <= phase + 2'd1;
        end
    end

    // Phase 0 is the tick, so the first clock out of reset ticks
    assign tick = (phase == 2'd0);

    //////////////////////////////
    // Position counters
    //////////////////////////////

    coord_t h_count;
    coord_t v_count;
    logic   line_end;
    logic   frame_end;

    // Last pixel of a line, last line of a frame
    assign line_end  = (h_count == coord_t'(`H_TOTAL - 1));
    assign frame_end = (v_count == coord_t'(`V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (tick) begin
            if (line_end) begin
                h_count <= '0;
                // Vertical steps once per line
                if (frame_end) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + coord_t'(1);
                end
            end else begin
                h_count <= h_count + coord_t'(1);
            end
        end
    end

    //////////////////////////////
    // Sync and blanking decode
    //////////////////////////////

    logic h_in_sync;
    logic v_in_sync;
    logic h_visible;
    logic v_visible;

    // Sync windows are [start, end)
    assign h_in_sync = (h_count >= coord_t'(`H_SYNC_START)) &&
                       (h_count <  coord_t'(`H_SYNC_END));
    assign v_in_sync = (v_count >= coord_t'(`V_SYNC_START)) &&
                       (v_count <  coord_t'(`V_SYNC_END));

    assign h_visible = (h_count < coord_t'(`H_ACTIVE));
    assign v_visible = (v_count < coord_t'(`V_ACTIVE));

    // Drive the bundle
    assign vid.pixel_tick = tick;
    assign vid.x          = h_count;
    assign vid.y          = v_count;
    // Both syncs are negative polarity in this mode
    assign vid.hsync      = ~h_in_sync;
    assign vid.vsync      = ~v_in_sync;
    assign vid.active     = h_visible && v_visible;

endmodule

// ==== hw/video_if.sv ====
`timescale 1ns/1ps

interface video_if;

    import display_pkg::*;

    // One clock high per pixel
    logic   pixel_tick;

    // Current raster position
    coord_t x;
    coord_t y;

    // High inside the visible area
    logic   active;

    // Active low syncs
    logic   hsync;
    logic   vsync;

    // Raster generator side
    modport source (
        output pixel_tick,
        output x,
        output y,
        output active,
        output hsync,
        output vsync
    );

    // Circle comparator only looks at position
    modport compare (
        input pixel_tick,
        input x,
        input y
    );

    // Colour stage needs the levels, not the position
    modport shade (
        input pixel_tick,
        input active,
        input hsync,
        input vsync
    );

endinterface

// ==== test/circle_display_assertions.sv ====
`timescale 1ns/1ps

module circle_display_assertions (
    input logic                       clk,
    input logic                       reset,
    input logic                       pixel_tick,
    input display_pkg::circle_state_t state,
    input logic                       in_circle
);

    import display_pkg::*;

    // Number of assertion failures so far
    int fail_count = 0;

    //////////////////////////////
    // Strobe alignment
    //////////////////////////////

    // Comparator sits in INIT only on the tick clock
    a_init_on_tick: assert property (
        @(posedge clk) disable iff (reset) (state == INIT) == pixel_tick
    ) else begin
        $error("comparator state out of step with pixel_tick");
        fail_count++;
    end

    //////////////////////////////
    // State order
    //////////////////////////////

    a_init_next: assert property (
        @(posedge clk) disable iff (reset) state == INIT |=> state == SQUARE_X
    ) else begin
        $error("INIT not followed by SQUARE_X");
        fail_count++;
    end

    a_square_x_next: assert property (
        @(posedge clk) disable iff (reset) state == SQUARE_X |=> state == SQUARE_Y
    ) else begin
        $error("SQUARE_X not followed by SQUARE_Y");
        fail_count++;
    end

    a_square_y_next: assert property (
        @(posedge clk) disable iff (reset) state == SQUARE_Y |=> state == ADD_CMP
    ) else begin
        $error("SQUARE_Y not followed by ADD_CMP");
        fail_count++;
    end

    a_add_cmp_next: assert property (
        @(posedge clk) disable iff (reset) state == ADD_CMP |=> state == INIT
    ) else begin
        $error("ADD_CMP not followed by INIT");
        fail_count++;
    end

    // Result register only moves when leaving ADD_CMP
    a_result_edge: assert property (
        @(posedge clk) disable iff (reset)
        (in_circle != $past(in_circle)) |-> ($past(state) == ADD_CMP)
    ) else begin
        $error("in_circle changed outside the ADD_CMP edge");
        fail_count++;
    end

endmodule

// Attach to every comparator instance
bind circle_test circle_display_assertions circle_checks0 (
    .clk        (clk),
    .reset      (reset),
    .pixel_tick (vid.pixel_tick),
    .state      (state),
    .in_circle  (in_circle)
);

// ==== test/circle_display_tb.sv ====
`timescale 1ns/1ps
`include "display_consts.svh"

module circle_display_tb;

    import display_pkg::*;

    //////////////////////////////
    // Run limits
    //////////////////////////////

    localparam int CLK_PERIOD_NS = 100;
    // Clocks in one whole frame
    localparam longint FRAME_CLKS = longint'(`H_TOTAL) * `V_TOTAL * `CLKS_PER_PIXEL;
    // Three frames plus one line of margin
    localparam longint WATCHDOG_NS =
        (3 * FRAME_CLKS + `H_TOTAL * `CLKS_PER_PIXEL) * CLK_PERIOD_NS;

    logic   clk;
    logic   reset;
    logic   hsync;
    logic   vsync;
    pixel_t rgb;

    int error_count;
    int check_count;
    // Failures seen by the bound comparator checker
    int assertion_failures;
    // Raster position of the next pixel to be checked
    int model_x;
    int model_y;

    circle_display dut0 (
        .clk   (clk),
        .reset (reset),
        .hsync (hsync),
        .vsync (vsync),
        .rgb   (rgb)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    // Hard stop if the tests never finish
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic compare_level(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0d ns: %s expected %b, got %b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_pixel(input string name, input pixel_t expected,
                                 input pixel_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0d ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    //////////////////////////////
    // Reference raster model
    //////////////////////////////

    // Active low inside [start, end)
    function automatic logic expected_hsync(input int x);
        return !(x >= `H_SYNC_START && x < `H_SYNC_END);
    endfunction

    function automatic logic expected_vsync(input int y);
        return !(y >= `V_SYNC_START && y < `V_SYNC_END);
    endfunction

    function automatic pixel_t expected_rgb(input int x, input int y);
        int dx;
        int dy;
        dx = x - `CENTER_X;
        dy = y - `CENTER_Y;
        // Blanking is black
        if (x >= `H_ACTIVE || y >= `V_ACTIVE) return '0;
        // Boundary counts as outside
        if (dx * dx + dy * dy < `RADIUS_SQ) return `INSIDE_COLOR;
        return `OUTSIDE_COLOR;
    endfunction

    task automatic advance_model();
        model_x++;
        if (model_x == `H_TOTAL) begin
            model_x = 0;
            model_y++;
            if (model_y == `V_TOTAL) model_y = 0;
        end
    endtask

    // Wait out one pixel and compare mid-pixel against the model
    task automatic check_pixel();
        repeat (`CLKS_PER_PIXEL) @(posedge clk);
        #1;
        compare_level("hsync", expected_hsync(model_x), hsync);
        compare_level("vsync", expected_vsync(model_y), vsync);
        compare_pixel("rgb", expected_rgb(model_x, model_y), rgb);
        advance_model();
    endtask

    task automatic check_idle_outputs();
        compare_level("hsync", 1'b1, hsync);
        compare_level("vsync", 1'b1, vsync);
        compare_pixel("rgb", 12'h000, rgb);
    endtask

    // Two reset cycles then stop two clocks past the first tick edge
    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end
        reset = 1'b0;
        // Pixel 0 enters the pipeline on the first tick edge
        @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
        // Pixel 0 not out yet
        check_idle_outputs();
        model_x = 0;
        model_y = 0;
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic test_reset_state();
        apply_reset();
    endtask

    // Colours and sync windows over one frame
    task automatic test_full_frame();
        repeat (`H_TOTAL * `V_TOTAL) check_pixel();
    endtask

    // Runs into the centre line and stops just past pixel 420
    task automatic test_circle_boundary();
        int px;
        int py;
        px = -1;
        py = -1;
        while (!(py == `CENTER_Y && px == 420)) begin
            px = model_x;
            py = model_y;
            check_pixel();
            if (py == `CENTER_Y) begin
                // Exactly on the radius at 220 and 420
                if (px == 220 || px == 420) begin
                    compare_pixel("rgb boundary", `OUTSIDE_COLOR, rgb);
                end else if (px == 221 || px == 419) begin
                    compare_pixel("rgb boundary", `INSIDE_COLOR, rgb);
                end
            end
        end
    endtask

    // Raster must restart at pixel 0 of line 0 after a mid-line reset
    task automatic test_mid_frame_reset();
        apply_reset();
        repeat (2 * `H_TOTAL) check_pixel();
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        error_count = 0;
        check_count = 0;
        assertion_failures = 0;
        model_x = 0;
        model_y = 0;

        test_reset_state();
        test_full_frame();
        test_circle_boundary();
        test_mid_frame_reset();

        assertion_failures = dut0.circle0.circle_checks0.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, assertion_failures);
        if (error_count == 0 && assertion_failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
